// ==== rtl/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

  localparam int NODES = 2;
  localparam int FLIT_W = 32;

  // one tile buffers at most a full packet
  localparam int TILE_MAX_WORDS = 16;

  // reply header: src id on top, word count in the low half, rest zero
  localparam int HDR_SRC_BIT = 31;
  localparam int HDR_LEN_W = 16;

  typedef logic [$clog2(NODES)-1:0] node_id_t;

  typedef struct packed {
    logic [FLIT_W-1:0] data;
    logic              last;
  } noc_beat_t;

endpackage

`default_nettype wire

// ==== rtl/host_pkg.sv ====
`default_nettype none

package host_pkg;

  localparam int HOST_W = 32;
  localparam int EGRESS_DEPTH = 4;

  typedef noc_pkg::node_id_t host_dest_t; // host picks a tile by its id

  typedef struct packed {
    logic [HOST_W-1:0] data;
    logic              last;
  } host_beat_t;

endpackage

`default_nettype wire

// ==== rtl/flit_link.sv ====
`timescale 1ns/1ps
`default_nettype none

interface flit_link
  import noc_pkg::*;
();

  logic [FLIT_W-1:0] flit;
  logic              last;
  logic              valid;
  logic              ready;

  // beat moves on an edge with valid and ready both high
  modport tx (
    output flit, last, valid,
    input  ready
  );

  modport rx (
    input  flit, last, valid,
    output ready
  );

endinterface

`default_nettype wire

// ==== rtl/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module flit_fifo #(
  parameter type T = logic,
  parameter int DEPTH = 4
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic wr_en_i,
  input  T     wr_data_i,
  output logic full_o,
  input  logic rd_en_i,
  output T     rd_data_o,
  output logic empty_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [AW-1:0] LAST_IDX = AW'(DEPTH - 1);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  T              mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign full_o  = (count == FULL_CNT);
  assign empty_o = (count == '0);
  assign do_wr   = wr_en_i && !full_o;
  assign do_rd   = rd_en_i && !empty_o;

  assign rd_data_o = mem[rd_ptr]; // head is visible without a read strobe

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/host_ingress.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_ingress
  import noc_pkg::*;
  import host_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              host_req_i,
  output logic              host_ack_o,
  input  logic [HOST_W-1:0] host_data_i,
  input  node_id_t          host_dest_i,
  input  logic              host_last_i,
  flit_link.tx              link0,
  flit_link.tx              link1
);

  logic              ack_q;
  logic [NODES-1:0]  valid_q;
  logic [NODES-1:0]  link_ready;
  logic [HOST_W-1:0] flit_q;
  logic              last_q;
  logic              take;

  assign link_ready = {link1.ready, link0.ready};

  // accept only from a closed handshake and a ready target link
  assign take = host_req_i && !ack_q && link_ready[host_dest_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      valid_q <= '0;
    end else begin
      valid_q <= valid_q & ~link_ready; // drop valid once the beat is taken
      if (take) begin
        ack_q                <= 1'b1;
        valid_q[host_dest_i] <= 1'b1;
      end else if (ack_q && !host_req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      flit_q <= host_data_i;
      last_q <= host_last_i;
    end
  end

  assign host_ack_o = ack_q;

  // both links see the same payload, valid goes to the target only
  assign link0.flit  = FLIT_W'(flit_q);
  assign link0.last  = last_q;
  assign link0.valid = valid_q[0];
  assign link1.flit  = FLIT_W'(flit_q);
  assign link1.last  = last_q;
  assign link1.valid = valid_q[1];

endmodule

`default_nettype wire

// ==== rtl/compute_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module compute_tile
  import noc_pkg::*;
#(
  parameter node_id_t TILE_ID = '0
) (
  input  logic clk_i,
  input  logic reset_i,
  flit_link.rx in_link,
  flit_link.tx out_link
);

  typedef enum logic [1:0] {
    S_COLLECT,
    S_HDR,
    S_BODY,
    S_TRAIL
  } state_t;

  state_t                            state_q;
  logic [$clog2(TILE_MAX_WORDS):0]   cnt_q;
  logic [FLIT_W-1:0]                 sum_q;
  logic [FLIT_W-1:0]                 hdr;
  noc_beat_t                         push_beat;
  noc_beat_t                         pop_beat;
  logic                              fifo_full;
  logic                              fifo_empty;
  logic                              push;
  logic                              pop;
  logic                              out_fire;

  assign push_beat.data = in_link.flit;
  assign push_beat.last = in_link.last;

  assign in_link.ready = (state_q == S_COLLECT) && !fifo_full;
  assign push          = in_link.valid && in_link.ready;

  flit_fifo #(
    .T     (noc_beat_t),
    .DEPTH (TILE_MAX_WORDS)
  ) u_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (push),
    .wr_data_i (push_beat),
    .full_o    (fifo_full),
    .rd_en_i   (pop),
    .rd_data_o (pop_beat),
    .empty_o   (fifo_empty)
  );

  always_comb begin
    hdr                  = '0;
    hdr[HDR_SRC_BIT]     = TILE_ID;
    hdr[HDR_LEN_W-1:0]   = HDR_LEN_W'(cnt_q);
  end

  always_comb begin
    case (state_q)
      S_HDR:   out_link.flit = hdr;
      S_BODY:  out_link.flit = pop_beat.data;
      default: out_link.flit = sum_q;
    endcase
  end

  assign out_link.valid = (state_q == S_HDR) || (state_q == S_TRAIL) ||
                          (state_q == S_BODY && !fifo_empty);
  assign out_link.last  = (state_q == S_TRAIL);
  assign out_fire       = out_link.valid && out_link.ready;
  assign pop            = out_fire && (state_q == S_BODY);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= S_COLLECT;
      cnt_q   <= '0;
      sum_q   <= '0;
    end else begin
      case (state_q)
        S_COLLECT: if (push) begin
          cnt_q <= cnt_q + 1'b1;
          sum_q <= sum_q + in_link.flit; // wraps at 32 bits
          if (in_link.last) state_q <= S_HDR;
        end
        S_HDR: if (out_fire) state_q <= S_BODY;
        S_BODY: if (pop && pop_beat.last) state_q <= S_TRAIL;
        S_TRAIL: if (out_fire) begin
          state_q <= S_COLLECT;
          cnt_q   <= '0;
          sum_q   <= '0;
        end
        default: state_q <= S_COLLECT;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/noc_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module noc_merge
  import noc_pkg::*;
  import host_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,
  flit_link.rx              in0,
  flit_link.rx              in1,
  output logic              out_req_o,
  input  logic              out_ack_i,
  output logic [HOST_W-1:0] out_data_o,
  output logic              out_last_o
);

  typedef enum logic [1:0] {
    E_IDLE,
    E_REQ,
    E_CLOSE
  } eg_state_t;

  logic [NODES-1:0]  in_valid;
  logic [NODES-1:0]  in_last;
  logic [NODES-1:0]  in_ready;
  logic [FLIT_W-1:0] in_flit [NODES];

  node_id_t   ptr_q;     // round-robin favourite, or the locked link
  node_id_t   other;
  node_id_t   sel;
  logic       locked_q;
  logic       xfer;
  logic       stage_valid_q;
  host_beat_t stage_q;
  logic       stage_ready;
  logic       fifo_full;
  logic       fifo_empty;
  host_beat_t head;
  logic       pop;
  eg_state_t  eg_q;

  assign in_valid   = {in1.valid, in0.valid};
  assign in_last    = {in1.last, in0.last};
  assign in_flit[0] = in0.flit;
  assign in_flit[1] = in1.flit;
  assign in0.ready  = in_ready[0];
  assign in1.ready  = in_ready[1];

  assign other = ~ptr_q;

  always_comb begin
    if (locked_q) sel = ptr_q;
    else if (!in_valid[ptr_q] && in_valid[other]) sel = other;
    else sel = ptr_q;
  end

  // stage register empties into the FIFO unless it is full
  assign stage_ready = !stage_valid_q || !fifo_full;

  always_comb begin
    in_ready      = '0;
    in_ready[sel] = stage_ready;
  end

  assign xfer = in_valid[sel] && stage_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q         <= '0;
      locked_q      <= 1'b0;
      stage_valid_q <= 1'b0;
    end else begin
      if (stage_ready) stage_valid_q <= xfer;
      if (xfer) begin
        locked_q <= !in_last[sel];
        ptr_q    <= in_last[sel] ? ~sel : sel; // hand over after last
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      stage_q.data <= HOST_W'(in_flit[sel]);
      stage_q.last <= in_last[sel];
    end
  end

  flit_fifo #(
    .T     (host_beat_t),
    .DEPTH (EGRESS_DEPTH)
  ) u_egress_fifo (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (stage_valid_q),
    .wr_data_i (stage_q),
    .full_o    (fifo_full),
    .rd_en_i   (pop),
    .rd_data_o (head),
    .empty_o   (fifo_empty)
  );

  // four-phase sender, head word stays put while req is high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      eg_q <= E_IDLE;
    end else begin
      case (eg_q)
        E_IDLE:  if (!fifo_empty) eg_q <= E_REQ;
        E_REQ:   if (out_ack_i) eg_q <= E_CLOSE;
        E_CLOSE: if (!out_ack_i) eg_q <= E_IDLE;
        default: eg_q <= E_IDLE;
      endcase
    end
  end

  assign pop        = (eg_q == E_REQ) && out_ack_i;
  assign out_req_o  = (eg_q == E_REQ);
  assign out_data_o = head.data;
  assign out_last_o = head.last;

endmodule

`default_nettype wire

// ==== rtl/mpsoc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module mpsoc_lite
  import noc_pkg::*;
  import host_pkg::*;
(
  input  logic              clk_i,
  input  logic              reset_i,

  input  logic              host_req_i,
  output logic              host_ack_o,
  input  logic [HOST_W-1:0] host_data_i,
  input  host_dest_t        host_dest_i,
  input  logic              host_last_i,

  output logic              out_req_o,
  input  logic              out_ack_i,
  output logic [HOST_W-1:0] out_data_o,
  output logic              out_last_o
);

  flit_link in_link0 ();
  flit_link in_link1 ();
  flit_link out_link0 ();
  flit_link out_link1 ();

  host_ingress u_ingress (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_req_i  (host_req_i),
    .host_ack_o  (host_ack_o),
    .host_data_i (host_data_i),
    .host_dest_i (host_dest_i),
    .host_last_i (host_last_i),
    .link0       (in_link0),
    .link1       (in_link1)
  );

  for (genvar i = 0; i < NODES; i++) begin : gen_tile
    if (i == 0) begin : g_t0
      compute_tile #(
        .TILE_ID (node_id_t'(i))
      ) u_tile (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .in_link  (in_link0),
        .out_link (out_link0)
      );
    end else begin : g_t1
      compute_tile #(
        .TILE_ID (node_id_t'(i))
      ) u_tile (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .in_link  (in_link1),
        .out_link (out_link1)
      );
    end
  end

  noc_merge u_merge (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in0        (out_link0),
    .in1        (out_link1),
    .out_req_o  (out_req_o),
    .out_ack_i  (out_ack_i),
    .out_data_o (out_data_o),
    .out_last_o (out_last_o)
  );

endmodule

`default_nettype wire

// ==== test/tb_mpsoc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mpsoc_lite
  import noc_pkg::*;
  import host_pkg::*;
();

  localparam int N_ENTRIES = 9;
  localparam logic [HOST_W-1:0] WORD_STEP = 32'h0101_0101;

  typedef struct {
    node_id_t          dest;
    int                len;
    logic [HOST_W-1:0] base;
    logic              conc;   // next entry starts without waiting for this reply
    int                dly_lo;
    int                dly_hi;
  } entry_t;

  logic              clk_i = 1'b0;
  logic              reset_i;
  logic              host_req_i;
  logic              host_ack_o;
  logic [HOST_W-1:0] host_data_i;
  node_id_t          host_dest_i;
  logic              host_last_i;
  logic              out_req_o;
  logic              out_ack_i;
  logic [HOST_W-1:0] out_data_o;
  logic              out_last_o;

  entry_t          tbl [N_ENTRIES];
  logic [HOST_W:0] exp_q [2][$]; // {data, last} per source tile
  logic            in_pkt = 1'b0;
  node_id_t        cur_src = '0;
  int              value_errors = 0;
  int              proto_errors = 0;
  int              dly_lo = 0;
  int              dly_hi = 0;

  always #50 clk_i = ~clk_i;

  mpsoc_lite mpsoc_lite_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_req_i  (host_req_i),
    .host_ack_o  (host_ack_o),
    .host_data_i (host_data_i),
    .host_dest_i (host_dest_i),
    .host_last_i (host_last_i),
    .out_req_o   (out_req_o),
    .out_ack_i   (out_ack_i),
    .out_data_o  (out_data_o),
    .out_last_o  (out_last_o)
  );

  task automatic load_table();
    tbl[0] = '{1'b0, 4, 32'h1000_0000, 1'b0, 0, 2};
    tbl[1] = '{1'b1, 1, 32'hdead_beef, 1'b0, 0, 1};
    tbl[2] = '{1'b1, 16, 32'hf000_0001, 1'b0, 0, 3}; // sum wraps
    tbl[3] = '{1'b0, 5, 32'h0a0b_0c0d, 1'b1, 0, 2};
    tbl[4] = '{1'b1, 7, 32'h7000_0000, 1'b1, 0, 2};
    tbl[5] = '{1'b0, 3, 32'h0000_0011, 1'b0, 0, 2};
    // slow egress keeps tile 0 replying when entry 8 arrives
    tbl[6] = '{1'b0, 16, 32'h1234_5678, 1'b1, 6, 12};
    tbl[7] = '{1'b1, 12, 32'h8765_4321, 1'b1, 6, 12};
    tbl[8] = '{1'b0, 2, 32'h5555_aaaa, 1'b0, 6, 12};
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [HOST_W-1:0] got,
                                 input logic [HOST_W-1:0] exp);
    $display("FAILED %s got %h expected %h", name, got, exp);
    value_errors++;
  endtask

  task automatic protocol_error(input string msg);
    $display("ERROR: %s", msg);
    proto_errors++;
  endtask

  task automatic print_counts();
    $display("checks done: %0d value errors, %0d protocol errors", value_errors, proto_errors);
  endtask

  function automatic logic [HOST_W-1:0] word_at(input logic [HOST_W-1:0] base, input int i);
    return base + HOST_W'(i) * WORD_STEP;
  endfunction

  // reply is the header, the words as sent, then their sum with last
  task automatic expect_reply(input entry_t e);
    logic [HOST_W-1:0] hdr;
    logic [HOST_W-1:0] sum;
    logic [HOST_W-1:0] w;
    hdr = '0;
    hdr[HDR_SRC_BIT] = e.dest;
    hdr[HDR_LEN_W-1:0] = HDR_LEN_W'(e.len);
    sum = '0;
    exp_q[e.dest].push_back({hdr, 1'b0});
    for (int i = 0; i < e.len; i++) begin
      w = word_at(e.base, i);
      sum = sum + w;
      exp_q[e.dest].push_back({w, 1'b0});
    end
    exp_q[e.dest].push_back({sum, 1'b1});
  endtask

  task automatic send_word(input logic [HOST_W-1:0] data, input node_id_t dest,
                           input logic last);
    host_data_i = data;
    host_dest_i = dest;
    host_last_i = last;
    host_req_i  = 1'b1;
    do next_cycle(); while (!host_ack_o);
    host_req_i = 1'b0;
    do next_cycle(); while (host_ack_o);
  endtask

  task automatic send_packet(input entry_t e);
    for (int i = 0; i < e.len; i++) begin
      send_word(word_at(e.base, i), e.dest, i == e.len - 1);
    end
  endtask

  task automatic wait_drained();
    int budget;
    budget = 40 * (exp_q[0].size() + exp_q[1].size()) + 100; // per word still owed
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0 || in_pkt) && budget > 0) begin
      next_cycle();
      budget--;
    end
  endtask

  // header picks the queue and the rest of the packet must come from that tile
  task automatic check_word(input logic [HOST_W-1:0] data, input logic last);
    logic [HOST_W:0] exp;
    if (!in_pkt) begin
      cur_src = data[HDR_SRC_BIT];
      in_pkt  = 1'b1;
    end
    assert (exp_q[cur_src].size() > 0) else
      protocol_error($sformatf("egress word %h with no reply pending from tile %0d",
                               data, cur_src));
    if (exp_q[cur_src].size() > 0) begin
      exp = exp_q[cur_src].pop_front();
      assert (data == exp[HOST_W:1]) else report_mismatch("out_data_o", data, exp[HOST_W:1]);
      assert (last == exp[0]) else report_mismatch("out_last_o", HOST_W'(last), HOST_W'(exp[0]));
    end
    if (last) in_pkt = 1'b0;
  endtask

  initial begin : egress_responder
    int dly;
    out_ack_i = 1'b0;
    forever begin
      next_cycle();
      if (out_req_o) begin
        check_word(out_data_o, out_last_o);
        dly = dly_lo + int'($urandom % (dly_hi - dly_lo + 1));
        repeat (dly) next_cycle();
        out_ack_i = 1'b1;
        do next_cycle(); while (out_req_o);
        out_ack_i = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int limit;
    @(negedge reset_i);
    limit = 1000;
    for (int k = 0; k < N_ENTRIES; k++) begin
      limit += 40 * tbl[k].len;
    end
    repeat (limit) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", limit);
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : main_seq
    void'($urandom(32'h25c1_577a));
    reset_i     = 1'b1;
    host_req_i  = 1'b0;
    host_data_i = '0;
    host_dest_i = '0;
    host_last_i = 1'b0;
    load_table();
    repeat (16) next_cycle();
    reset_i = 1'b0;

    repeat (8) begin // quiet outputs before any request
      next_cycle();
      assert (host_ack_o == 1'b0) else report_mismatch("host_ack_o", HOST_W'(host_ack_o), '0);
      assert (out_req_o == 1'b0) else report_mismatch("out_req_o", HOST_W'(out_req_o), '0);
    end

    for (int k = 0; k < N_ENTRIES; k++) begin
      dly_lo = tbl[k].dly_lo;
      dly_hi = tbl[k].dly_hi;
      expect_reply(tbl[k]);
      send_packet(tbl[k]);
      if (!tbl[k].conc) wait_drained();
    end

    repeat (60) next_cycle(); // stray out_req_o lands in check_word
    assert (exp_q[0].size() == 0) else
      protocol_error($sformatf("tile 0 reply missing, %0d words never arrived", exp_q[0].size()));
    assert (exp_q[1].size() == 0) else
      protocol_error($sformatf("tile 1 reply missing, %0d words never arrived", exp_q[1].size()));

    print_counts();
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/noc_pkg.sv
rtl/host_pkg.sv
rtl/flit_link.sv
rtl/flit_fifo.sv
rtl/host_ingress.sv
rtl/compute_tile.sv
rtl/noc_merge.sv
rtl/mpsoc_lite.sv
test/tb_mpsoc_lite.sv

// ==== Makefile ====
TOP := tb_mpsoc_lite

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module mpsoc_lite
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
